/* cfg_pkg.sv */
// ##############################
// Register map and register width
// of the configuration block
// ##############################
package cfg_pkg;

    // All configuration registers are one word wide
    localparam int unsigned RegWidth     = 32;
    // Four word addresses are decoded
    localparam int unsigned CfgAddrWidth = 2;

    // Key applied to job data, read and write
    localparam logic [CfgAddrWidth-1:0] AddrKey      = 2'd0;

    // Number of results handed out so far, read only
    localparam logic [CfgAddrWidth-1:0] AddrDoneCnt  = 2'd1;

    // Number of worker lanes built into the design, read only
    localparam logic [CfgAddrWidth-1:0] AddrNumLanes = 2'd2;

    // Address 3 is unused and reads as zero

endpackage

/* dispatch_cfg_regs.sv */
// ##############################
// Configuration registers with the job key
// and the completed-job counter
// ##############################
`timescale 1ns/1ns

module dispatch_cfg_regs
    import cfg_pkg::*;
#(
    parameter int unsigned NumLanes = 4
) (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    cfg_we_i,
    input  logic [CfgAddrWidth-1:0] cfg_addr_i,
    input  logic [RegWidth-1:0]     cfg_wdata_i,
    output logic [RegWidth-1:0]     cfg_rdata_o,
    input  logic                    done_i,
    output logic [RegWidth-1:0]     key_o
);

    logic [RegWidth-1:0] key_q;
    logic [RegWidth-1:0] done_cnt_q;

    // Only the key is writable
    // Writes to the count and lane number land nowhere
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            key_q <= '0;
        end else if (cfg_we_i && (cfg_addr_i == AddrKey)) begin
            key_q <= cfg_wdata_i;
        end
    end

    // One count per result handed out, wrapping at the register width
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            done_cnt_q <= '0;
        end else if (done_i) begin
            done_cnt_q <= done_cnt_q + RegWidth'(1);
        end
    end

    // Read data follows the address in the same cycle
    always_comb begin
        case (cfg_addr_i)
            AddrKey: begin
                cfg_rdata_o = key_q;
            end
            AddrDoneCnt: begin
                cfg_rdata_o = done_cnt_q;
            end
            AddrNumLanes: begin
                cfg_rdata_o = RegWidth'(NumLanes);
            end
            default: begin
                cfg_rdata_o = '0;
            end
        endcase
    end

    // Every lane samples this value when it accepts a job
    assign key_o = key_q;

endmodule

/* dispatch_pkg.sv */
// ##############################
// Job and result payload types, field widths
// and the lane index width helper
// ##############################
package dispatch_pkg;

    // Width of the data word carried by every job
    localparam int unsigned DataWidth  = 32;
    // Width of the job tag that comes back with the result
    localparam int unsigned IdWidth    = 8;
    // Number of low id bits that set how long a lane holds a job
    localparam int unsigned DelayWidth = 2;

    // A job as it enters the dispatcher
    typedef struct packed {
        logic [IdWidth-1:0]   id;
        logic [DataWidth-1:0] data;
    } job_t;

    // A finished job, the data is already combined with the key
    typedef struct packed {
        logic [IdWidth-1:0]   id;
        logic [DataWidth-1:0] data;
    } result_t;

    // Bits needed to index num_idx entries, one bit even for a single entry
    function automatic int unsigned idx_width(input int unsigned num_idx);
        if (num_idx > 32'd1) begin
            return $clog2(num_idx);
        end
        return 32'd1;
    endfunction

endpackage

/* job_dispatcher_assert.sv */
// ##############################
// Bound checker with a reference queue of
// accepted jobs and register shadows
// ##############################
`timescale 1ns/1ns

module job_dispatcher_assert
    import dispatch_pkg::*;
    import cfg_pkg::*;
#(
    parameter int unsigned NumLanes = 4
) (
    input logic                    clk_i,
    input logic                    rst_ni,
    input logic                    job_valid_i,
    input logic                    job_ready_o,
    input logic [IdWidth-1:0]      job_id_i,
    input logic [DataWidth-1:0]    job_data_i,
    input logic                    res_valid_o,
    input logic                    res_ready_i,
    input logic [IdWidth-1:0]      res_id_o,
    input logic [DataWidth-1:0]    res_data_o,
    input logic                    cfg_we_i,
    input logic [CfgAddrWidth-1:0] cfg_addr_i,
    input logic [RegWidth-1:0]     cfg_wdata_i,
    input logic [RegWidth-1:0]     cfg_rdata_o
);

    int unsigned          err_cnt = 0;
    // Accepted jobs not yet returned, oldest first, data already keyed
    result_t              ref_q[$];
    int unsigned          exp_cnt;
    logic [IdWidth-1:0]   exp_id;
    logic [DataWidth-1:0] exp_data;
    logic [RegWidth-1:0]  ref_done;
    logic [RegWidth-1:0]  ref_key;

    // The key shadow is read before this edge's write lands, as the lane sees it
    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ref_q.delete();
            exp_cnt  <= 0;
            exp_id   <= '0;
            exp_data <= '0;
            ref_done <= '0;
            ref_key  <= '0;
        end else begin
            if (res_valid_o && res_ready_i && (ref_q.size() != 0)) begin
                void'(ref_q.pop_front());
                ref_done <= ref_done + RegWidth'(1);
            end
            if (job_valid_i && job_ready_o) begin
                ref_q.push_back(result_t'({job_id_i, job_data_i ^ ref_key}));
            end
            if (cfg_we_i && (cfg_addr_i == AddrKey)) begin
                ref_key <= cfg_wdata_i;
            end
            exp_cnt  <= ref_q.size();
            exp_id   <= (ref_q.size() != 0) ? ref_q[0].id : '0;
            exp_data <= (ref_q.size() != 0) ? ref_q[0].data : '0;
        end
    end

    a_reset_state: assert property (@(posedge clk_i)
        $rose(rst_ni) |-> (!res_valid_o && job_ready_o))
        else begin
            err_cnt++;
            $error("Outputs are not in their reset state after reset release");
        end

    a_res_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
        res_valid_o |-> (exp_cnt != 0))
        else begin
            err_cnt++;
            $error("A result came out with no accepted job waiting for it");
        end

    a_res_id: assert property (@(posedge clk_i) disable iff (!rst_ni)
        res_valid_o |-> (res_id_o == exp_id))
        else begin
            err_cnt++;
            $error("FAILED %0t res_id_o got %0h expected %0h",
                $time, $sampled(res_id_o), $sampled(exp_id));
        end

    a_res_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
        res_valid_o |-> (res_data_o == exp_data))
        else begin
            err_cnt++;
            $error("FAILED %0t res_data_o got %0h expected %0h",
                $time, $sampled(res_data_o), $sampled(exp_data));
        end

    // A stalled result must not move or drop
    a_res_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (res_valid_o && !res_ready_i) |=>
            (res_valid_o && $stable(res_id_o) && $stable(res_data_o)))
        else begin
            err_cnt++;
            $error("A stalled result changed or dropped its valid");
        end

    a_full_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (exp_cnt >= NumLanes) |-> !job_ready_o)
        else begin
            err_cnt++;
            $error("Input stayed ready with every lane holding a job");
        end

    a_done_cnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (cfg_addr_i == AddrDoneCnt) |-> (cfg_rdata_o == ref_done))
        else begin
            err_cnt++;
            $error("FAILED %0t cfg_rdata_o got %0h expected %0h",
                $time, $sampled(cfg_rdata_o), $sampled(ref_done));
        end

    a_key_read: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (cfg_addr_i == AddrKey) |-> (cfg_rdata_o == ref_key))
        else begin
            err_cnt++;
            $error("FAILED %0t cfg_rdata_o got %0h expected %0h",
                $time, $sampled(cfg_rdata_o), $sampled(ref_key));
        end

    a_num_lanes: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (cfg_addr_i == AddrNumLanes) |-> (cfg_rdata_o == RegWidth'(NumLanes)))
        else begin
            err_cnt++;
            $error("FAILED %0t cfg_rdata_o got %0h expected %0h",
                $time, $sampled(cfg_rdata_o), NumLanes);
        end

endmodule

/* job_dispatcher_top.sv */
// ##############################
// Job dispatcher top level with distributor,
// worker lanes, collector and registers
// ##############################
`timescale 1ns/1ns

module job_dispatcher_top
    import dispatch_pkg::*;
    import cfg_pkg::*;
#(
    parameter int unsigned NumLanes = 4,
    parameter bit          StrictRR = 1'b1
) (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    job_valid_i,
    output logic                    job_ready_o,
    input  logic [IdWidth-1:0]      job_id_i,
    input  logic [DataWidth-1:0]    job_data_i,
    output logic                    res_valid_o,
    input  logic                    res_ready_i,
    output logic [IdWidth-1:0]      res_id_o,
    output logic [DataWidth-1:0]    res_data_o,
    input  logic                    cfg_we_i,
    input  logic [CfgAddrWidth-1:0] cfg_addr_i,
    input  logic [RegWidth-1:0]     cfg_wdata_i,
    output logic [RegWidth-1:0]     cfg_rdata_o
);

    localparam int unsigned LaneIdxWidth = idx_width(NumLanes);

    job_t                    job_in;
    logic [NumLanes-1:0]     lane_job_valid;
    logic [NumLanes-1:0]     lane_job_ready;
    job_t [NumLanes-1:0]     lane_job;
    logic [LaneIdxWidth-1:0] sel;
    logic                    issue;
    logic [NumLanes-1:0]     lane_res_valid;
    logic [NumLanes-1:0]     lane_res_ready;
    result_t [NumLanes-1:0]  lane_res;
    logic [RegWidth-1:0]     key;
    logic                    done;

    assign job_in.id   = job_id_i;
    assign job_in.data = job_data_i;

    // A job is queued for ordering only when it was really accepted by a lane
    assign issue = job_valid_i & job_ready_o;

    rr_distributor #(
        .NumOut   (NumLanes),
        .data_t   (job_t),
        .StrictRR (StrictRR)
    ) rr_distributor_inst (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .valid_i   (job_valid_i),
        .ready_o   (job_ready_o),
        .payload_i (job_in),
        .valid_o   (lane_job_valid),
        .ready_i   (lane_job_ready),
        .payload_o (lane_job),
        .sel_o     (sel)
    );

    for (genvar k = 0; k < NumLanes; k++) begin : gen_lanes
        job_lane job_lane_inst (
            .clk_i       (clk_i),
            .rst_ni      (rst_ni),
            .job_valid_i (lane_job_valid[k]),
            .job_ready_o (lane_job_ready[k]),
            .job_i       (lane_job[k]),
            .key_i       (key),
            .res_valid_o (lane_res_valid[k]),
            .res_ready_i (lane_res_ready[k]),
            .res_o       (lane_res[k])
        );
    end

    order_collector #(
        .NumLanes (NumLanes)
    ) order_collector_inst (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .push_i       (issue),
        .push_idx_i   (sel),
        .lane_valid_i (lane_res_valid),
        .lane_ready_o (lane_res_ready),
        .lane_res_i   (lane_res),
        .res_valid_o  (res_valid_o),
        .res_ready_i  (res_ready_i),
        .res_id_o     (res_id_o),
        .res_data_o   (res_data_o),
        .done_o       (done)
    );

    dispatch_cfg_regs #(
        .NumLanes (NumLanes)
    ) dispatch_cfg_regs_inst (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .cfg_we_i    (cfg_we_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_wdata_i (cfg_wdata_i),
        .cfg_rdata_o (cfg_rdata_o),
        .done_i      (done),
        .key_o       (key)
    );

endmodule

/* job_lane.sv */
// ##############################
// Worker lane that holds one job for its
// requested delay, then offers the keyed result
// ##############################
`timescale 1ns/1ns

module job_lane
    import dispatch_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 job_valid_i,
    output logic                 job_ready_o,
    input  job_t                 job_i,
    input  logic [DataWidth-1:0] key_i,
    output logic                 res_valid_o,
    input  logic                 res_ready_i,
    output result_t              res_o
);

    // One extra bit so that the loaded value delay + 1 fits
    localparam int unsigned CntWidth = DelayWidth + 1;

    logic                full_q;
    logic [CntWidth-1:0] cnt_q;
    result_t             res_q;
    logic                accept;
    logic                take;

    // The lane takes a new job only while it holds none
    assign job_ready_o = ~full_q;
    assign accept      = job_valid_i & job_ready_o;

    // The result shows once the hold counter has run down
    assign res_valid_o = full_q & (cnt_q == '0);
    assign take        = res_valid_o & res_ready_i;

    // Occupancy and hold counter
    // Loading delay + 1 puts the result valid 1 + delay cycles after acceptance
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            full_q <= 1'b0;
            cnt_q  <= '0;
        end else if (accept) begin
            full_q <= 1'b1;
            cnt_q  <= CntWidth'(job_i.id[DelayWidth-1:0]) + CntWidth'(1);
        end else begin
            // Freed by the take, so the lane is ready again in the next cycle
            if (take) begin
                full_q <= 1'b0;
            end
            if (full_q && (cnt_q != '0)) begin
                cnt_q <= cnt_q - CntWidth'(1);
            end
        end
    end

    // The key is sampled here, a later key write leaves a held job alone
    always_ff @(posedge clk_i) begin
        if (accept) begin
            res_q.id   <= job_i.id;
            res_q.data <= job_i.data ^ key_i;
        end
    end

    // The result register only changes on acceptance, so it stays put until taken
    assign res_o = res_q;

endmodule

/* order_collector.sv */
// ##############################
// Collector that returns lane results in
// the order the jobs were issued
// ##############################
`timescale 1ns/1ns

module order_collector
    import dispatch_pkg::*;
#(
    parameter int unsigned NumLanes = 4,
    // Derived from NumLanes, leave at its default
    parameter int unsigned IdxWidth = idx_width(NumLanes)
) (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   push_i,
    input  logic [IdxWidth-1:0]    push_idx_i,
    input  logic [NumLanes-1:0]    lane_valid_i,
    output logic [NumLanes-1:0]    lane_ready_o,
    input  result_t [NumLanes-1:0] lane_res_i,
    output logic                   res_valid_o,
    input  logic                   res_ready_i,
    output logic [IdWidth-1:0]     res_id_o,
    output logic [DataWidth-1:0]   res_data_o,
    output logic                   done_o
);

    // The count has to reach NumLanes itself, so it may need one bit more
    localparam int unsigned CntWidth = idx_width(NumLanes + 1);

    // Lane indices in issue order, at most one entry per lane
    logic [IdxWidth-1:0] idx_mem [NumLanes];
    logic [IdxWidth-1:0] wr_ptr_q;
    logic [IdxWidth-1:0] rd_ptr_q;
    logic [CntWidth-1:0] count_q;
    logic [IdxWidth-1:0] head_idx;
    logic                empty;
    logic                pop;

    // Step a queue pointer, wrapping at the lane count
    function automatic logic [IdxWidth-1:0] next_ptr(input logic [IdxWidth-1:0] ptr);
        if (ptr == IdxWidth'(NumLanes - 1)) begin
            return '0;
        end
        return ptr + IdxWidth'(1);
    endfunction

    assign empty    = (count_q == '0);
    assign head_idx = idx_mem[rd_ptr_q];

    // Only the oldest outstanding lane is looked at, younger lanes wait even when done
    assign res_valid_o = ~empty & lane_valid_i[head_idx];
    assign res_id_o    = lane_res_i[head_idx].id;
    assign res_data_o  = lane_res_i[head_idx].data;

    assign pop    = res_valid_o & res_ready_i;
    assign done_o = pop;

    // The head lane sees the downstream ready, so its take matches the output transfer
    always_comb begin
        lane_ready_o = '0;
        if (!empty) begin
            lane_ready_o[head_idx] = res_ready_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            // Push and pop in one cycle leave the count unchanged
            if (push_i && !pop) begin
                count_q <= count_q + CntWidth'(1);
            end else if (pop && !push_i) begin
                count_q <= count_q - CntWidth'(1);
            end
        end
    end

    // Only jobs in flight are stored, and never more than there are lanes
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            idx_mem[wr_ptr_q] <= push_idx_i;
        end
    end

endmodule

/* rr_distributor.sv */
// ##############################
// Round-robin distributor that steers one
// valid/ready stream to several outputs
// ##############################
`timescale 1ns/1ns

module rr_distributor
    import dispatch_pkg::*;
#(
    parameter int unsigned NumOut   = 1,
    parameter type         data_t   = logic,
    parameter bit          StrictRR = 1'b1,
    // Derived from NumOut, leave at its default
    parameter int unsigned IdxWidth = idx_width(NumOut)
) (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                valid_i,
    output logic                ready_o,
    input  data_t               payload_i,
    output logic [NumOut-1:0]   valid_o,
    input  logic [NumOut-1:0]   ready_i,
    output data_t [NumOut-1:0]  payload_o,
    output logic [IdxWidth-1:0] sel_o
);

    // Every output sees the same payload, only valid tells an output it is addressed
    assign payload_o = {NumOut{payload_i}};

    if (NumOut == 1) begin : gen_single
        // Nothing to choose from, so the stream passes straight through
        assign valid_o[0] = valid_i;
        assign ready_o    = ready_i[0];
        assign sel_o      = '0;
    end else begin : gen_rr
        logic [IdxWidth-1:0] rr_q;
        logic [IdxWidth-1:0] rr_d;
        logic                any_ready;

        assign any_ready = |ready_i;

        // The pointer moves on after a transfer to the current output
        // In the relaxed mode it also moves on when some other output could take the job,
        // so a busy output does not stall the input for long
        always_comb begin
            rr_d = rr_q;
            if (valid_i && (ready_i[rr_q] || (any_ready && !StrictRR))) begin
                if (rr_q == IdxWidth'(NumOut - 1)) begin
                    rr_d = '0;
                end else begin
                    rr_d = rr_q + IdxWidth'(1);
                end
            end
        end

        always_ff @(posedge clk_i or negedge rst_ni) begin
            if (!rst_ni) begin
                rr_q <= '0;
            end else begin
                rr_q <= rr_d;
            end
        end

        // Only the output under the pointer is offered the job
        always_comb begin
            valid_o       = '0;
            valid_o[rr_q] = valid_i;
        end

        assign ready_o = ready_i[rr_q];

        // The pointer names the output that takes the job in a transfer this cycle
        assign sel_o = rr_q;
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build with Verilator, run, and judge the log
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_job_dispatcher -f sim.f -o tb_sim \
    && ./obj_dir/tb_sim +verilator+error+limit+1000 > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }

cat sim.log
grep -q "Finished with errors" sim.log \
    && { echo "Simulation FAILED"; exit 1; } \
    || { echo "Simulation PASSED"; exit 0; }

/* sim.f */
dispatch_pkg.sv
cfg_pkg.sv
rr_distributor.sv
job_lane.sv
order_collector.sv
dispatch_cfg_regs.sv
job_dispatcher_top.sv
job_dispatcher_assert.sv
tb_job_dispatcher.sv

/* tb_job_dispatcher.sv */
// ##############################
// Testbench for the job dispatcher with clock,
// reset, random jobs, back-pressure and watchdog
// ##############################
`timescale 1ns/1ns

module tb_job_dispatcher
    import dispatch_pkg::*;
    import cfg_pkg::*;
();

    localparam int unsigned NumLanes       = 4;
    localparam bit          StrictRR       = 1'b1;
    localparam int unsigned NumStreamJobs  = 40;
    localparam int unsigned NumIdleJobs    = 8;
    localparam int unsigned NumJobs        = NumLanes + NumStreamJobs + NumIdleJobs;
    // Ten cycles per job is far more than the worst lane delay plus stalls
    localparam int unsigned WatchdogCycles = NumJobs * 10 + 100;

    logic                    clk_i;
    logic                    rst_ni;
    logic                    job_valid_i;
    logic                    job_ready_o;
    logic [IdWidth-1:0]      job_id_i;
    logic [DataWidth-1:0]    job_data_i;
    logic                    res_valid_o;
    logic                    res_ready_i;
    logic [IdWidth-1:0]      res_id_o;
    logic [DataWidth-1:0]    res_data_o;
    logic                    cfg_we_i;
    logic [CfgAddrWidth-1:0] cfg_addr_i;
    logic [RegWidth-1:0]     cfg_wdata_i;
    logic [RegWidth-1:0]     cfg_rdata_o;

    logic [31:0] rng_state = 32'h7f77fe0e;
    // 0 holds results back, 1 takes them at random, 2 always takes them
    int unsigned ready_mode = 0;
    int unsigned jobs_sent  = 0;
    int unsigned tb_errs    = 0;

    job_dispatcher_top #(
        .NumLanes (NumLanes),
        .StrictRR (StrictRR)
    ) job_dispatcher_top_inst (.*);

    bind job_dispatcher_top job_dispatcher_assert #(
        .NumLanes (NumLanes)
    ) job_dispatcher_assert_inst (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .job_valid_i (job_valid_i),
        .job_ready_o (job_ready_o),
        .job_id_i    (job_id_i),
        .job_data_i  (job_data_i),
        .res_valid_o (res_valid_o),
        .res_ready_i (res_ready_i),
        .res_id_o    (res_id_o),
        .res_data_o  (res_data_o),
        .cfg_we_i    (cfg_we_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_wdata_i (cfg_wdata_i),
        .cfg_rdata_o (cfg_rdata_o)
    );

    // Linear congruential generator, one shared stream for all stimulus
    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // All tasks start and end just after a falling edge
    task automatic send_job(input logic [IdWidth-1:0] id, input logic [DataWidth-1:0] data);
        logic accepted;
        job_valid_i = 1'b1;
        job_id_i    = id;
        job_data_i  = data;
        accepted    = 1'b0;
        // Ready only depends on lane state, so it is settled at the falling edge
        while (!accepted) begin
            accepted = job_ready_o;
            @(negedge clk_i);
        end
        job_valid_i = 1'b0;
        jobs_sent++;
    endtask

    task automatic write_key(input logic [RegWidth-1:0] key_val);
        cfg_we_i    = 1'b1;
        cfg_addr_i  = AddrKey;
        cfg_wdata_i = key_val;
        @(negedge clk_i);
        cfg_we_i    = 1'b0;
    endtask

    task automatic read_reg(input logic [CfgAddrWidth-1:0] addr);
        cfg_addr_i = addr;
        @(negedge clk_i);
    endtask

    // Wait until the done counter has caught up with every job sent
    task automatic wait_done(input int unsigned count);
        read_reg(AddrDoneCnt);
        while (cfg_rdata_o != RegWidth'(count)) begin
            @(negedge clk_i);
        end
    endtask

    task automatic finish_run();
        int unsigned assert_errs;
        assert_errs = job_dispatcher_top_inst.job_dispatcher_assert_inst.err_cnt;
        $display("Error count: %0d assertion, %0d testbench", assert_errs, tb_errs);
        if ((assert_errs + tb_errs) == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // Result side back-pressure pattern
    initial begin
        logic [31:0] rand_word;
        res_ready_i = 1'b0;
        forever begin
            @(negedge clk_i);
            if (ready_mode == 2) begin
                res_ready_i = 1'b1;
            end else if (ready_mode == 1) begin
                rand_word   = next_rand();
                res_ready_i = rand_word[16];
            end else begin
                res_ready_i = 1'b0;
            end
        end
    end

    initial begin
        repeat (WatchdogCycles) @(posedge clk_i);
        $display("Watchdog expired before all jobs came back");
        tb_errs++;
        finish_run();
    end

    initial begin
        rst_ni      = 1'b0;
        job_valid_i = 1'b0;
        job_id_i    = '0;
        job_data_i  = '0;
        cfg_we_i    = 1'b0;
        cfg_addr_i  = AddrDoneCnt;
        cfg_wdata_i = '0;
        repeat (10) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;

        // Register setup, reset values first
        read_reg(AddrDoneCnt);
        read_reg(AddrKey);
        read_reg(AddrNumLanes);
        write_key(next_rand());
        read_reg(AddrKey);
        read_reg(AddrDoneCnt);

        // Fill every lane with results held back, delays falling from 3 to 0
        for (int unsigned i = 0; i < NumLanes; i++) begin
            send_job(IdWidth'((i + 1) * 4 + (3 - (i % 4))), next_rand());
        end
        while (job_ready_o) begin
            @(negedge clk_i);
        end

        // Streaming with random gaps and random back-pressure
        ready_mode = 1;
        for (int unsigned i = 0; i < NumStreamJobs; i++) begin
            repeat (next_rand() % 3) @(negedge clk_i);
            send_job(IdWidth'(next_rand()), next_rand());
        end

        // Key change once everything has come back
        ready_mode = 2;
        wait_done(jobs_sent);
        write_key(next_rand());
        read_reg(AddrKey);
        for (int unsigned i = 0; i < NumIdleJobs; i++) begin
            send_job(IdWidth'(next_rand()), next_rand());
        end

        // Final drain
        wait_done(jobs_sent);
        read_reg(AddrKey);
        read_reg(AddrNumLanes);
        finish_run();
    end

endmodule
